/* common/mem_pkg.sv */
package mem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    localparam int MEM_WORDS_LOG2 = 10; // 4 KiB from address 0

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    localparam logic [7:0] LFSR_SEED = 8'h01;

    // indexed by lfsr[7:6]
    localparam logic [7:0] DELAY_0 = 8'd5;
    localparam logic [7:0] DELAY_1 = 8'd10;
    localparam logic [7:0] DELAY_2 = 8'd20;
    localparam logic [7:0] DELAY_3 = 8'd15;

endpackage

/* sram/sram_array.sv */
module sram_array (
    input  logic                               clk,
    input  logic                               mem_en,
    input  logic                               mem_we,
    input  logic [mem_pkg::MEM_WORDS_LOG2-1:0] mem_addr,
    input  logic [mem_pkg::STRB_W-1:0]         mem_wstrb,
    input  logic [mem_pkg::DATA_W-1:0]         mem_wdata,
    output logic [mem_pkg::DATA_W-1:0]         mem_rdata
);

    logic [mem_pkg::DATA_W-1:0] mem [0:(1 << mem_pkg::MEM_WORDS_LOG2)-1];

    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                for (int i = 0; i < mem_pkg::STRB_W; i++) begin
                    if (mem_wstrb[i]) begin
                        mem[mem_addr][i*8 +: 8] <= mem_wdata[i*8 +: 8];
                    end
                end
            end else begin
                mem_rdata <= mem[mem_addr]; // holds until the next read
            end
        end
    end

endmodule

/* sram/sram_slave.sv */
module sram_slave (
    input  logic                               clk,
    input  logic                               rst,

    input  logic [mem_pkg::ADDR_W-1:0]         araddr,
    input  logic                               arvalid,
    output logic                               arready,

    output logic [mem_pkg::DATA_W-1:0]         rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  logic                               rready,

    input  logic [mem_pkg::ADDR_W-1:0]         awaddr,
    input  logic                               awvalid,
    output logic                               awready,

    input  logic [mem_pkg::DATA_W-1:0]         wdata,
    input  logic [mem_pkg::STRB_W-1:0]         wstrb,
    input  logic                               wvalid,
    output logic                               wready,

    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  logic                               bready,

    output logic                               mem_en,
    output logic                               mem_we,
    output logic [mem_pkg::MEM_WORDS_LOG2-1:0] mem_addr,
    output logic [mem_pkg::STRB_W-1:0]         mem_wstrb,
    output logic [mem_pkg::DATA_W-1:0]         mem_wdata,
    input  logic [mem_pkg::DATA_W-1:0]         mem_rdata
);

    logic                               busy;
    logic                               is_write;
    logic [1:0]                         resp;
    logic [7:0]                         lfsr;
    logic [7:0]                         delay_count;
    logic [7:0]                         target_delay;
    logic [mem_pkg::MEM_WORDS_LOG2-1:0] word_addr;
    logic [mem_pkg::DATA_W-1:0]         write_data;
    logic [mem_pkg::STRB_W-1:0]         write_strb;
    logic [mem_pkg::ADDR_W-1:0]         sel_addr;
    logic                               lfsr_tap;
    logic                               ar_go;
    logic                               aw_go;
    logic                               in_range;
    logic                               fire;
    logic                               rsp_done;

    function automatic logic [7:0] pick_delay(input logic [7:0] value);
        case (value[7:6])
            2'b00:   pick_delay = mem_pkg::DELAY_0;
            2'b01:   pick_delay = mem_pkg::DELAY_1;
            2'b10:   pick_delay = mem_pkg::DELAY_2;
            default: pick_delay = mem_pkg::DELAY_3;
        endcase
    endfunction

    assign lfsr_tap = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    // reads win if both show up at once
    assign ar_go = !busy && arvalid && arready;
    assign aw_go = !busy && !arvalid && awvalid && awready;

    assign sel_addr = ar_go ? araddr : awaddr;
    assign in_range = (sel_addr[mem_pkg::ADDR_W-1:mem_pkg::MEM_WORDS_LOG2+2] == '0);

    // last cycle of the delay, the array access happens here
    assign fire     = busy && (delay_count == target_delay - 8'd1);
    assign rsp_done = (rvalid && rready) || (bvalid && bready);

    assign mem_en    = fire && (resp == mem_pkg::RESP_OKAY); // out of range never touches the array
    assign mem_we    = is_write;
    assign mem_addr  = word_addr;
    assign mem_wstrb = write_strb;
    assign mem_wdata = write_data;

    assign rdata = (resp == mem_pkg::RESP_OKAY) ? mem_rdata : '0;
    assign rresp = resp;
    assign bresp = resp;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr         <= mem_pkg::LFSR_SEED;
            busy         <= 1'b0;
            is_write     <= 1'b0;
            resp         <= mem_pkg::RESP_OKAY;
            delay_count  <= 8'd0;
            target_delay <= 8'd0;
            arready      <= 1'b1;
            awready      <= 1'b1;
            wready       <= 1'b0;
            rvalid       <= 1'b0;
            bvalid       <= 1'b0;
        end else begin
            if (ar_go || aw_go) begin
                lfsr         <= {lfsr[6:0], lfsr_tap};
                target_delay <= pick_delay(lfsr);
                delay_count  <= 8'd0;
                busy         <= 1'b1;
                is_write     <= aw_go;
                resp         <= in_range ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
                arready      <= 1'b0;
                awready      <= 1'b0;
                wready       <= aw_go;
            end
            if (busy) begin
                if (wvalid && wready) begin
                    wready <= 1'b0;
                end
                if (delay_count < target_delay) begin
                    delay_count <= delay_count + 8'd1;
                end
                if (fire) begin
                    rvalid <= !is_write;
                    bvalid <= is_write;
                end
                if (rsp_done) begin
                    busy    <= 1'b0;
                    rvalid  <= 1'b0;
                    bvalid  <= 1'b0;
                    arready <= 1'b1;
                    awready <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_go || aw_go) begin
            word_addr <= sel_addr[mem_pkg::MEM_WORDS_LOG2+1:2];
        end
        if (wvalid && wready) begin // w arrives well before the delay ends
            write_data <= wdata;
            write_strb <= wstrb;
        end
    end

endmodule

/* design/fetch_port.sv */
module fetch_port (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       fetch_req,
    input  logic [mem_pkg::ADDR_W-1:0] fetch_pc,
    output logic                       fetch_done,
    output logic [mem_pkg::DATA_W-1:0] fetch_inst,
    output logic                       fetch_err,

    output logic [mem_pkg::ADDR_W-1:0] f_araddr,
    output logic                       f_arvalid,
    input  logic                       f_arready,
    input  logic [mem_pkg::DATA_W-1:0] f_rdata,
    input  logic [1:0]                 f_rresp,
    input  logic                       f_rvalid,
    output logic                       f_rready
);

    logic waiting; // address taken, data still to come
    logic start;

    // idle means neither address nor wait phase
    assign start    = fetch_req && !f_arvalid && !waiting && !fetch_done;
    assign f_rready = waiting;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            f_arvalid  <= 1'b0;
            waiting    <= 1'b0;
            fetch_done <= 1'b0;
            fetch_err  <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            if (start) begin
                f_arvalid <= 1'b1;
            end
            if (f_arvalid && f_arready) begin
                f_arvalid <= 1'b0;
                waiting   <= 1'b1;
            end
            if (f_rvalid && f_rready) begin
                waiting    <= 1'b0;
                fetch_done <= 1'b1;
                fetch_err  <= (f_rresp != mem_pkg::RESP_OKAY);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            f_araddr <= {fetch_pc[mem_pkg::ADDR_W-1:2], 2'b00}; // word aligned
        end
        if (f_rvalid && f_rready) begin
            fetch_inst <= f_rdata;
        end
    end

endmodule

/* design/lsu_port.sv */
module lsu_port (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       lsu_req,
    input  logic                       lsu_we,
    input  logic [mem_pkg::ADDR_W-1:0] lsu_addr,
    input  logic [mem_pkg::DATA_W-1:0] lsu_wdata,
    input  logic [mem_pkg::STRB_W-1:0] lsu_wstrb,
    output logic                       lsu_done,
    output logic [mem_pkg::DATA_W-1:0] lsu_rdata,
    output logic                       lsu_err,

    output logic [mem_pkg::ADDR_W-1:0] l_araddr,
    output logic                       l_arvalid,
    input  logic                       l_arready,
    input  logic [mem_pkg::DATA_W-1:0] l_rdata,
    input  logic [1:0]                 l_rresp,
    input  logic                       l_rvalid,
    output logic                       l_rready,

    output logic [mem_pkg::ADDR_W-1:0] l_awaddr,
    output logic                       l_awvalid,
    input  logic                       l_awready,
    output logic [mem_pkg::DATA_W-1:0] l_wdata,
    output logic [mem_pkg::STRB_W-1:0] l_wstrb,
    output logic                       l_wvalid,
    input  logic                       l_wready,
    input  logic [1:0]                 l_bresp,
    input  logic                       l_bvalid,
    output logic                       l_bready
);

    logic                       pending; // issued, no response yet
    logic                       start;
    logic                       rsp_fire;
    logic [mem_pkg::ADDR_W-1:0] req_addr;

    assign start    = lsu_req && !pending && !lsu_done;
    assign rsp_fire = (l_rvalid && l_rready) || (l_bvalid && l_bready);

    assign l_araddr = req_addr;
    assign l_awaddr = req_addr;
    assign l_rready = pending;
    assign l_bready = pending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            l_arvalid <= 1'b0;
            l_awvalid <= 1'b0;
            l_wvalid  <= 1'b0;
            pending   <= 1'b0;
            lsu_done  <= 1'b0;
            lsu_err   <= 1'b0;
        end else begin
            lsu_done <= 1'b0;
            if (start) begin
                pending   <= 1'b1;
                l_arvalid <= !lsu_we;
                l_awvalid <= lsu_we; // aw and w go out together
                l_wvalid  <= lsu_we;
            end
            // each valid drops on its own transfer
            if (l_arvalid && l_arready) begin
                l_arvalid <= 1'b0;
            end
            if (l_awvalid && l_awready) begin
                l_awvalid <= 1'b0;
            end
            if (l_wvalid && l_wready) begin
                l_wvalid <= 1'b0;
            end
            if (rsp_fire) begin
                pending  <= 1'b0;
                lsu_done <= 1'b1;
                lsu_err  <= l_rvalid ? (l_rresp != mem_pkg::RESP_OKAY)
                                     : (l_bresp != mem_pkg::RESP_OKAY);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_addr <= {lsu_addr[mem_pkg::ADDR_W-1:2], 2'b00};
            l_wdata  <= lsu_wdata;
            l_wstrb  <= lsu_wstrb;
        end
        if (l_rvalid && l_rready) begin
            lsu_rdata <= l_rdata;
        end
    end

endmodule

/* design/mem_arbiter.sv */
module mem_arbiter (
    input  logic                       clk,
    input  logic                       rst,

    // fetch master, read only
    input  logic [mem_pkg::ADDR_W-1:0] f_araddr,
    input  logic                       f_arvalid,
    output logic                       f_arready,
    output logic [mem_pkg::DATA_W-1:0] f_rdata,
    output logic [1:0]                 f_rresp,
    output logic                       f_rvalid,
    input  logic                       f_rready,

    // load/store master
    input  logic [mem_pkg::ADDR_W-1:0] l_araddr,
    input  logic                       l_arvalid,
    output logic                       l_arready,
    output logic [mem_pkg::DATA_W-1:0] l_rdata,
    output logic [1:0]                 l_rresp,
    output logic                       l_rvalid,
    input  logic                       l_rready,
    input  logic [mem_pkg::ADDR_W-1:0] l_awaddr,
    input  logic                       l_awvalid,
    output logic                       l_awready,
    input  logic [mem_pkg::DATA_W-1:0] l_wdata,
    input  logic [mem_pkg::STRB_W-1:0] l_wstrb,
    input  logic                       l_wvalid,
    output logic                       l_wready,
    output logic [1:0]                 l_bresp,
    output logic                       l_bvalid,
    input  logic                       l_bready,

    // toward the slave
    output logic [mem_pkg::ADDR_W-1:0] araddr,
    output logic                       arvalid,
    input  logic                       arready,
    input  logic [mem_pkg::DATA_W-1:0] rdata,
    input  logic [1:0]                 rresp,
    input  logic                       rvalid,
    output logic                       rready,
    output logic [mem_pkg::ADDR_W-1:0] awaddr,
    output logic                       awvalid,
    input  logic                       awready,
    output logic [mem_pkg::DATA_W-1:0] wdata,
    output logic [mem_pkg::STRB_W-1:0] wstrb,
    output logic                       wvalid,
    input  logic                       wready,
    input  logic [1:0]                 bresp,
    input  logic                       bvalid,
    output logic                       bready
);

    logic busy;
    logic gnt_l;  // 1 while the lsu owns the channel
    logic last_l; // lsu was served last
    logic f_req;
    logic l_req;
    logic pick_l;
    logic rsp_fire;

    assign f_req    = f_arvalid;
    assign l_req    = l_arvalid || l_awvalid;
    assign pick_l   = l_req && (!f_req || !last_l);
    assign rsp_fire = (rvalid && rready) || (bvalid && bready);

    // only the writer is the lsu, so the write payload needs no mux
    assign araddr  = gnt_l ? l_araddr : f_araddr;
    assign arvalid = busy && (gnt_l ? l_arvalid : f_arvalid);
    assign rready  = busy && (gnt_l ? l_rready : f_rready);
    assign awaddr  = l_awaddr;
    assign awvalid = busy && gnt_l && l_awvalid;
    assign wdata   = l_wdata;
    assign wstrb   = l_wstrb;
    assign wvalid  = busy && gnt_l && l_wvalid;
    assign bready  = busy && gnt_l && l_bready;

    assign f_arready = busy && !gnt_l && arready;
    assign f_rvalid  = busy && !gnt_l && rvalid;
    assign f_rdata   = rdata;
    assign f_rresp   = rresp;

    assign l_arready = busy && gnt_l && arready;
    assign l_awready = busy && gnt_l && awready;
    assign l_wready  = busy && gnt_l && wready;
    assign l_rvalid  = busy && gnt_l && rvalid;
    assign l_bvalid  = busy && gnt_l && bvalid;
    assign l_rdata   = rdata;
    assign l_rresp   = rresp;
    assign l_bresp   = bresp;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            gnt_l  <= 1'b0;
            last_l <= 1'b0;
        end else if (!busy) begin
            if (f_req || l_req) begin
                busy   <= 1'b1;
                gnt_l  <= pick_l;
                last_l <= pick_l;
            end
        end else if (rsp_fire) begin
            busy <= 1'b0; // grant held through the response
        end
    end

endmodule

/* design/mem_subsys_top.sv */
module mem_subsys_top (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       fetch_req,
    input  logic [mem_pkg::ADDR_W-1:0] fetch_pc,
    output logic                       fetch_done,
    output logic [mem_pkg::DATA_W-1:0] fetch_inst,
    output logic                       fetch_err,

    input  logic                       lsu_req,
    input  logic                       lsu_we,
    input  logic [mem_pkg::ADDR_W-1:0] lsu_addr,
    input  logic [mem_pkg::DATA_W-1:0] lsu_wdata,
    input  logic [mem_pkg::STRB_W-1:0] lsu_wstrb,
    output logic                       lsu_done,
    output logic [mem_pkg::DATA_W-1:0] lsu_rdata,
    output logic                       lsu_err
);

    // names match the submodule ports, so instances connect implicitly
    logic [mem_pkg::ADDR_W-1:0]         f_araddr, l_araddr, l_awaddr, araddr, awaddr;
    logic [mem_pkg::DATA_W-1:0]         f_rdata, l_rdata, l_wdata, rdata, wdata;
    logic [mem_pkg::DATA_W-1:0]         mem_wdata, mem_rdata;
    logic [mem_pkg::STRB_W-1:0]         l_wstrb, wstrb, mem_wstrb;
    logic [1:0]                         f_rresp, l_rresp, l_bresp, rresp, bresp;
    logic [mem_pkg::MEM_WORDS_LOG2-1:0] mem_addr;
    logic                               f_arvalid, f_arready, f_rvalid, f_rready;
    logic                               l_arvalid, l_arready, l_rvalid, l_rready;
    logic                               l_awvalid, l_awready, l_wvalid, l_wready;
    logic                               l_bvalid, l_bready;
    logic                               arvalid, arready, rvalid, rready;
    logic                               awvalid, awready, wvalid, wready, bvalid, bready;
    logic                               mem_en, mem_we;

    fetch_port fetch_port_inst (.*);

    lsu_port lsu_port_inst (.*);

    mem_arbiter mem_arbiter_inst (.*);

    sram_slave sram_slave_inst (.*);

    sram_array sram_array_inst (.*);

endmodule

/* tb/tb_mem_subsys.sv */
module tb_mem_subsys;

    localparam int POOL_WORDS = 64; // words used by the random traffic
    localparam int WAIT_LIMIT = 200;

    logic                       clk;
    logic                       rst;
    logic                       fetch_req;
    logic [mem_pkg::ADDR_W-1:0] fetch_pc;
    logic                       fetch_done;
    logic [mem_pkg::DATA_W-1:0] fetch_inst;
    logic                       fetch_err;
    logic                       lsu_req;
    logic                       lsu_we;
    logic [mem_pkg::ADDR_W-1:0] lsu_addr;
    logic [mem_pkg::DATA_W-1:0] lsu_wdata;
    logic [mem_pkg::STRB_W-1:0] lsu_wstrb;
    logic                       lsu_done;
    logic [mem_pkg::DATA_W-1:0] lsu_rdata;
    logic                       lsu_err;

    logic [7:0] model_mem [0:4095]; // byte image of the 4 KiB array
    bit         written [0:1023];
    int         written_q[$];
    bit         last_lsu = 1'b0; // port that finished most recently
    int         word_errors = 0;
    int         flag_errors = 0;
    int         other_errors = 0;

    mem_subsys_top mem_subsys_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [mem_pkg::DATA_W-1:0] model_word(input int word);
        return {model_mem[word*4+3], model_mem[word*4+2], model_mem[word*4+1], model_mem[word*4]};
    endfunction

    function automatic void model_write(input int word, input logic [mem_pkg::DATA_W-1:0] data,
                                        input logic [mem_pkg::STRB_W-1:0] strb);
        for (int i = 0; i < mem_pkg::STRB_W; i++) begin
            if (strb[i]) begin
                model_mem[word*4+i] = data[i*8 +: 8];
            end
        end
        if (!written[word]) begin
            written[word] = 1'b1;
            written_q.push_back(word);
        end
    endfunction

    function automatic int pick_written();
        return written_q[$urandom % written_q.size()];
    endfunction

    task automatic check_word(input string name, input logic [mem_pkg::DATA_W-1:0] exp,
                              input logic [mem_pkg::DATA_W-1:0] act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            word_errors++;
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            flag_errors++;
        end
    endtask

    // called 1 unit after a rising edge, returns at the same point
    task automatic fetch_access(input string name, input logic [mem_pkg::ADDR_W-1:0] pc,
                                output logic [mem_pkg::DATA_W-1:0] inst, output logic err);
        int cycles;
        fetch_pc = pc;
        fetch_req = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!fetch_done && cycles < WAIT_LIMIT);
        fetch_req = 1'b0;
        if (!fetch_done) begin
            $display("%s: fetch_done never came within %0d cycles", name, WAIT_LIMIT);
            other_errors++;
        end else begin
            last_lsu = 1'b0;
        end
        inst = fetch_inst;
        err = fetch_err;
    endtask

    task automatic lsu_access(input string name, input logic we,
                              input logic [mem_pkg::ADDR_W-1:0] addr,
                              input logic [mem_pkg::DATA_W-1:0] wdata,
                              input logic [mem_pkg::STRB_W-1:0] strb,
                              output logic [mem_pkg::DATA_W-1:0] rdata, output logic err);
        int cycles;
        lsu_we = we;
        lsu_addr = addr;
        lsu_wdata = wdata;
        lsu_wstrb = strb;
        lsu_req = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!lsu_done && cycles < WAIT_LIMIT);
        lsu_req = 1'b0;
        if (!lsu_done) begin
            $display("%s: lsu_done never came within %0d cycles", name, WAIT_LIMIT);
            other_errors++;
        end else begin
            last_lsu = 1'b1;
        end
        rdata = lsu_rdata;
        err = lsu_err;
    endtask

    task automatic do_fetch(input string name, input int word);
        logic [mem_pkg::DATA_W-1:0] expected;
        logic [mem_pkg::DATA_W-1:0] inst;
        logic                       err;
        expected = model_word(word);
        fetch_access(name, (32'(word) << 2) | 32'($urandom % 4), inst, err); // low bits ignored
        check_word(name, expected, inst);
        check_err(name, 1'b0, err);
    endtask

    task automatic do_load(input string name, input int word);
        logic [mem_pkg::DATA_W-1:0] expected;
        logic [mem_pkg::DATA_W-1:0] rdata;
        logic                       err;
        expected = model_word(word);
        lsu_access(name, 1'b0, (32'(word) << 2) | 32'($urandom % 4), '0, '0, rdata, err);
        check_word(name, expected, rdata);
        check_err(name, 1'b0, err);
    endtask

    task automatic do_store(input string name, input int word,
                            input logic [mem_pkg::DATA_W-1:0] data,
                            input logic [mem_pkg::STRB_W-1:0] strb);
        logic [mem_pkg::DATA_W-1:0] rdata;
        logic                       err;
        lsu_access(name, 1'b1, 32'(word) << 2, data, strb, rdata, err);
        check_err(name, 1'b0, err);
        model_write(word, data, strb);
    endtask

    // first write to a word is full width so no byte stays unknown
    function automatic logic [mem_pkg::STRB_W-1:0] pick_strb(input int word);
        return written[word] ? 4'($urandom % 15 + 1) : 4'hf;
    endfunction

    task automatic run_fairness(input int rounds);
        int f_word;
        int l_word;
        int f_count;
        int l_count;
        int idle;
        int prev; // 0 fetch, 1 lsu
        bit stuck;
        f_word = pick_written();
        l_word = pick_written();
        f_count = 0;
        l_count = 0;
        idle = 0;
        prev = last_lsu ? 1 : 0; // round robin serves the other port first
        stuck = 1'b0;
        fetch_pc = 32'(f_word) << 2;
        lsu_we = 1'b0;
        lsu_addr = 32'(l_word) << 2;
        fetch_req = 1'b1;
        lsu_req = 1'b1;
        while ((f_count < rounds || l_count < rounds) && !stuck) begin
            @(posedge clk);
            #1;
            idle++;
            if (fetch_done) begin
                if (prev == 0) begin
                    $display("fairness: fetch finished twice in a row at round %0d", f_count);
                    other_errors++;
                end
                check_word("fairness fetch", model_word(f_word), fetch_inst);
                check_err("fairness fetch", 1'b0, fetch_err);
                f_count++;
                prev = 0;
                idle = 0;
                if (f_count == rounds) fetch_req = 1'b0;
            end
            if (lsu_done) begin
                if (prev == 1) begin
                    $display("fairness: lsu finished twice in a row at round %0d", l_count);
                    other_errors++;
                end
                check_word("fairness load", model_word(l_word), lsu_rdata);
                check_err("fairness load", 1'b0, lsu_err);
                l_count++;
                prev = 1;
                idle = 0;
                if (l_count == rounds) lsu_req = 1'b0;
            end
            if (idle >= WAIT_LIMIT) begin
                $display("fairness: no done pulse within %0d cycles", WAIT_LIMIT);
                other_errors++;
                stuck = 1'b1;
                fetch_req = 1'b0;
                lsu_req = 1'b0;
            end
        end
    endtask

    task automatic run_mixed(input int total);
        int issued;
        int kind;
        int fw;
        int lw;
        int gap;
        bit is_store;
        logic [mem_pkg::DATA_W-1:0] data;
        logic [mem_pkg::STRB_W-1:0] strb;
        issued = 0;
        while (issued < total) begin
            kind = (total - issued >= 2) ? $urandom % 4 : $urandom % 3; // pairs need two slots
            if (kind == 0) begin
                do_fetch("mixed fetch", pick_written());
                issued++;
            end else if (kind == 1) begin
                do_load("mixed load", pick_written());
                issued++;
            end else if (kind == 2) begin
                lw = $urandom % POOL_WORDS;
                do_store("mixed store", lw, $urandom, pick_strb(lw));
                issued++;
            end else begin
                fw = pick_written();
                do begin
                    lw = $urandom % POOL_WORDS;
                end while (lw == fw); // keeps the result independent of grant order
                is_store = !written[lw] || ($urandom % 2 == 1);
                data = $urandom;
                strb = pick_strb(lw);
                gap = $urandom % 4;
                fork
                    do_fetch("overlap fetch", fw);
                    begin
                        repeat (gap) begin
                            @(posedge clk);
                            #1;
                        end
                        if (is_store) do_store("overlap store", lw, data, strb);
                        else do_load("overlap load", lw);
                    end
                join
                issued += 2;
            end
        end
    endtask

    initial begin
        int word;
        logic [mem_pkg::ADDR_W-1:0] bad_addr;
        logic [mem_pkg::DATA_W-1:0] rdata;
        logic err;
        void'($urandom(32'h411b));
        rst = 1'b1;
        fetch_req = 1'b0;
        fetch_pc = '0;
        lsu_req = 1'b0;
        lsu_we = 1'b0;
        lsu_addr = '0;
        lsu_wdata = '0;
        lsu_wstrb = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (20) begin
            @(posedge clk);
            #1;
            check_err("reset fetch_done", 1'b0, fetch_done);
            check_err("reset lsu_done", 1'b0, lsu_done);
        end

        for (int i = 0; i < 60; i++) begin
            word = $urandom % POOL_WORDS;
            do_store("strobed write", word, $urandom, pick_strb(word));
            do_load("strobed readback", word);
        end

        for (int i = 0; i < 30; i++) begin
            do_fetch("fetch read", pick_written());
        end

        // out of range address aliasing a written word in its low bits
        word = pick_written();
        bad_addr = 32'h1000 + (32'(word) << 2);
        lsu_access("oor write", 1'b1, bad_addr, $urandom, 4'hf, rdata, err);
        check_err("oor write", 1'b1, err);
        lsu_access("oor load", 1'b0, bad_addr, '0, '0, rdata, err);
        check_word("oor load", '0, rdata);
        check_err("oor load", 1'b1, err);
        fetch_access("oor fetch", 32'h8000_0000 | bad_addr, rdata, err);
        check_word("oor fetch", '0, rdata);
        check_err("oor fetch", 1'b1, err);
        do_load("oor alias unchanged", word);

        run_fairness(20);
        run_mixed(300);

        $display("error counts: %0d data, %0d flag, %0d other",
                 word_errors, flag_errors, other_errors);
        if (word_errors + flag_errors + other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
common/mem_pkg.sv
sram/sram_array.sv
sram/sram_slave.sv
design/fetch_port.sv
design/lsu_port.sv
design/mem_arbiter.sv
design/mem_subsys_top.sv
tb/tb_mem_subsys.sv

/* Makefile */
SRCS := $(shell cat flist.f)

.PHONY: run clean

run: obj_dir/Vtb_mem_subsys
	@out="$$(./obj_dir/Vtb_mem_subsys)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Simulation PASSED$$'

obj_dir/Vtb_mem_subsys: flist.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_mem_subsys -f flist.f

clean:
	rm -rf obj_dir
